// File: logic/apple_placer.sv
`timescale 1ns/1ps
`include "snake_settings.svh"

module apple_placer (
	input  logic clk,
	input  logic rst,
	input  snake_pkg::game_state_t state,
	output snake_pkg::coord_x_t apple_x,
	output snake_pkg::coord_y_t apple_y
);
	import snake_pkg::*;

	logic [13:0] lfsr;

	// folds a 7 bit draw into the apple range, values >= span wrap once
	function automatic logic [6:0] fold(logic [6:0] raw);
		logic [6:0] v;
		v = (raw >= 7'(`APPLE_SPAN)) ? raw - 7'(`APPLE_SPAN) : raw;
		return v + 7'(`APPLE_OFFSET);
	endfunction

	// taps 14,13,12,2 give a maximal length sequence
	always_ff @(posedge clk) begin
		if (rst)
			lfsr <= 14'h1ace;
		else
			lfsr <= {lfsr[12:0], lfsr[13] ^ lfsr[12] ^ lfsr[11] ^ lfsr[1]};
	end

	// low half picks the column, high half the row
	always_ff @(posedge clk) begin
		if (state == st_place_apple) begin
			apple_x <= coord_x_t'(fold(lfsr[6:0]));
			apple_y <= coord_y_t'(fold(lfsr[13:7]));
		end
	end

endmodule

// File: logic/frame_painter.sv
`timescale 1ns/1ps
`include "snake_settings.svh"

module frame_painter (
	input  logic clk,
	input  logic rst,
	input  snake_pkg::game_state_t state,
	input  snake_pkg::snake_len_t snake_len,
	input  snake_pkg::coord_x_t apple_x,
	input  snake_pkg::coord_y_t apple_y,
	input  snake_pkg::coord_x_t seg_x,
	input  snake_pkg::coord_y_t seg_y,
	output snake_pkg::snake_len_t seg_index,
	output logic plot,
	output snake_pkg::coord_x_t draw_x,
	output snake_pkg::coord_y_t draw_y,
	output snake_pkg::colour_t colour,
	output logic phase_done
);
	import snake_pkg::*;

	pix_count_t pix_cnt;
	coord_x_t cnt_x;
	coord_y_t cnt_y;
	logic drawing;
	logic last_pixel;
	logic plot_next;
	coord_x_t x_next;
	coord_y_t y_next;
	colour_t colour_next;

	// column major scan, the row field also serves as segment index
	assign cnt_x = pix_cnt[14:7];
	assign cnt_y = pix_cnt[6:0];
	assign seg_index = snake_len_t'(cnt_y);
	assign last_pixel = (cnt_x == coord_x_t'(`SCREEN_W - 1))
		&& (cnt_y == coord_y_t'(`SCREEN_H - 1));
	assign drawing = state inside {st_clear, st_walls, st_apple, st_snake};

	always_comb begin
		case (state)
			st_clear, st_walls: phase_done = last_pixel;
			st_apple:           phase_done = 1'b1;
			st_snake:           phase_done = (seg_index == snake_len - 1'b1);
			default:            phase_done = 1'b0;
		endcase
	end

	// back to zero at each phase end so the next phase starts clean
	always_ff @(posedge clk) begin
		if (rst)
			pix_cnt <= '0;
		else if (phase_done || !drawing)
			pix_cnt <= '0;
		else if (cnt_y == coord_y_t'(`SCREEN_H - 1))
			pix_cnt <= {cnt_x + 1'b1, 7'd0};
		else
			pix_cnt <= pix_cnt + 1'b1;
	end

	always_comb begin
		plot_next = 1'b0;
		x_next = cnt_x;
		y_next = cnt_y;
		colour_next = black;
		case (state)
			st_clear: plot_next = 1'b1;
			st_walls: begin
				// only the band itself is painted
				plot_next = in_wall(cnt_x, cnt_y);
				colour_next = blue;
			end
			st_apple: begin
				plot_next = 1'b1;
				x_next = apple_x;
				y_next = apple_y;
				colour_next = red;
			end
			st_snake: begin
				// head first, seg_x/seg_y follow seg_index combinationally
				plot_next = 1'b1;
				x_next = seg_x;
				y_next = seg_y;
				colour_next = green;
			end
			default: plot_next = 1'b0;
		endcase
	end

	// pixel stream trails the scan by one clock
	always_ff @(posedge clk) begin
		if (rst)
			plot <= 1'b0;
		else
			plot <= plot_next;
	end

	always_ff @(posedge clk) begin
		draw_x <= x_next;
		draw_y <= y_next;
		colour <= colour_next;
	end

endmodule

// File: logic/snake_body.sv
`timescale 1ns/1ps
`include "snake_settings.svh"

module snake_body (
	input  logic clk,
	input  logic rst,
	input  snake_pkg::game_state_t state,
	input  snake_pkg::dir_t dir,
	input  snake_pkg::coord_x_t apple_x,
	input  snake_pkg::coord_y_t apple_y,
	input  snake_pkg::snake_len_t seg_index,
	output snake_pkg::coord_x_t seg_x,
	output snake_pkg::coord_y_t seg_y,
	output snake_pkg::snake_len_t snake_len,
	output logic apple_hit,
	output logic collision,
	output logic scan_done
);
	import snake_pkg::*;

	localparam int IDX_W = $clog2(`MAX_LEN);

	// entry 0 is the head, higher entries trail behind it
	coord_x_t body_x [`MAX_LEN];
	coord_y_t body_y [`MAX_LEN];
	coord_x_t head_x;
	coord_y_t head_y;
	coord_x_t next_x;
	coord_y_t next_y;
	snake_len_t scan_cnt;
	logic [IDX_W-1:0] scan_idx;
	logic scan_seg;
	logic seg_hit;

	assign head_x = body_x[0];
	assign head_y = body_y[0];
	assign seg_x = body_x[seg_index[IDX_W-1:0]];
	assign seg_y = body_y[seg_index[IDX_W-1:0]];
	assign apple_hit = (head_x == apple_x) && (head_y == apple_y);

	// scan walks segments 0..len-1, then spends one cycle on the walls
	assign scan_idx = scan_cnt[IDX_W-1:0];
	assign scan_seg = (scan_cnt < snake_len);
	assign scan_done = (state == st_check) && (scan_cnt == snake_len);
	// segment 0 is the head itself and never counts
	assign seg_hit = (scan_cnt != '0) && (body_x[scan_idx] == head_x)
		&& (body_y[scan_idx] == head_y);

	always_comb begin
		next_x = head_x;
		next_y = head_y;
		case (dir)
			dir_left:  next_x = head_x - 1'b1;
			dir_right: next_x = head_x + 1'b1;
			dir_down:  next_y = head_y + 1'b1;
			default:   next_y = head_y - 1'b1;
		endcase
	end

	// shift on each move, the old tail stays in entry len for growth
	always_ff @(posedge clk) begin
		if (state == st_load) begin
			for (int i = 0; i < `MAX_LEN; i++) begin
				body_x[i] <= coord_x_t'(`START_X + i);
				body_y[i] <= coord_y_t'(`START_Y);
			end
		end else if (state == st_moving) begin
			body_x[0] <= next_x;
			body_y[0] <= next_y;
			for (int i = 1; i < `MAX_LEN; i++) begin
				body_x[i] <= body_x[i-1];
				body_y[i] <= body_y[i-1];
			end
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			snake_len <= snake_len_t'(`START_LEN);
			collision <= 1'b0;
			scan_cnt <= '0;
		end else begin
			if (state == st_load)
				snake_len <= snake_len_t'(`START_LEN);
			else if (state == st_eating && snake_len < snake_len_t'(`MAX_LEN))
				snake_len <= snake_len + 1'b1;
			if (state == st_check)
				scan_cnt <= scan_cnt + 1'b1;
			else
				scan_cnt <= '0;
			// sticky until the next game is loaded
			if (state == st_load)
				collision <= 1'b0;
			else if (state == st_check && scan_seg && seg_hit)
				collision <= 1'b1;
			else if (state == st_check && !scan_seg && in_wall(head_x, head_y))
				collision <= 1'b1;
		end
	end

endmodule

// File: logic/snake_control.sv
`timescale 1ns/1ps
`include "snake_settings.svh"

module snake_control (
	input  logic clk,
	input  logic rst,
	input  logic btn_left,
	input  logic btn_right,
	input  logic btn_down,
	input  logic btn_up,
	input  logic phase_done,
	input  logic scan_done,
	input  logic collision,
	input  logic apple_hit,
	output snake_pkg::game_state_t state,
	output snake_pkg::dir_t dir,
	output logic game_over
);
	import snake_pkg::*;

	localparam int DELAY_W = $clog2(`DELAY_TICKS + 1);

	game_state_t state_next;
	dir_t dir_q;
	dir_t dir_turn;
	logic any_btn;
	logic [DELAY_W-1:0] delay_cnt;
	logic delay_done;

	// any direction button doubles as start
	assign any_btn = btn_left | btn_right | btn_down | btn_up;
	assign delay_done = (delay_cnt == DELAY_W'(`DELAY_TICKS - 1));

	// first held button that is not a reversal wins, left/right/down/up order
	always_comb begin
		dir_turn = dir_q;
		if (btn_left && dir_q != dir_right)
			dir_turn = dir_left;
		else if (btn_right && dir_q != dir_left)
			dir_turn = dir_right;
		else if (btn_down && dir_q != dir_up)
			dir_turn = dir_down;
		else if (btn_up && dir_q != dir_down)
			dir_turn = dir_up;
	end

	// body moves in st_moving and needs the new heading in that same cycle
	assign dir = (state == st_moving) ? dir_turn : dir_q;
	assign game_over = (state == st_dead);

	always_comb begin
		state_next = state;
		case (state)
			st_menu:        if (any_btn) state_next = st_starting;
			st_starting:    if (any_btn) state_next = st_start_wait;
			// hold off until every button is let go
			st_start_wait:  if (!any_btn) state_next = st_load;
			st_load:        state_next = st_place_apple;
			st_place_apple: state_next = st_clear;
			st_clear:       if (phase_done) state_next = st_walls;
			st_walls:       if (phase_done) state_next = st_apple;
			st_apple:       if (phase_done) state_next = st_snake;
			st_snake:       if (phase_done) state_next = st_delay;
			st_delay:       if (delay_done) state_next = st_moving;
			st_moving: begin
				// collision comes from the scan of the previous step
				if (collision)
					state_next = st_dead;
				else if (apple_hit)
					state_next = st_eating;
				else
					state_next = st_check;
			end
			st_check:       if (scan_done) state_next = st_clear;
			st_eating:      state_next = st_place_apple;
			st_dead:        state_next = st_menu;
			default:        state_next = st_menu;
		endcase
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= st_menu;
			dir_q <= dir_left;
			delay_cnt <= '0;
		end else begin
			state <= state_next;
			// a fresh game always heads left
			if (state == st_load)
				dir_q <= dir_left;
			else if (state == st_moving)
				dir_q <= dir_turn;
			// pause counter only runs inside st_delay
			if (state == st_delay)
				delay_cnt <= delay_cnt + 1'b1;
			else
				delay_cnt <= '0;
		end
	end

endmodule

// File: logic/snake_game.sv
`timescale 1ns/1ps

module snake_game (
	input  logic clk,
	input  logic rst,
	input  logic btn_left,
	input  logic btn_right,
	input  logic btn_down,
	input  logic btn_up,
	output logic plot,
	output snake_pkg::coord_x_t draw_x,
	output snake_pkg::coord_y_t draw_y,
	output snake_pkg::colour_t colour,
	output logic game_over,
	output snake_pkg::snake_len_t snake_len
);
	import snake_pkg::*;

	// control to datapath
	game_state_t state;
	dir_t dir;
	// datapath back to control
	logic phase_done;
	logic scan_done;
	logic collision;
	logic apple_hit;
	// shared positions
	coord_x_t apple_x;
	coord_y_t apple_y;
	coord_x_t seg_x;
	coord_y_t seg_y;
	snake_len_t seg_index;

	snake_control u_control (
		.clk        (clk),
		.rst        (rst),
		.btn_left   (btn_left),
		.btn_right  (btn_right),
		.btn_down   (btn_down),
		.btn_up     (btn_up),
		.phase_done (phase_done),
		.scan_done  (scan_done),
		.collision  (collision),
		.apple_hit  (apple_hit),
		.state      (state),
		.dir        (dir),
		.game_over  (game_over)
	);

	snake_body u_body (
		.clk       (clk),
		.rst       (rst),
		.state     (state),
		.dir       (dir),
		.apple_x   (apple_x),
		.apple_y   (apple_y),
		.seg_index (seg_index),
		.seg_x     (seg_x),
		.seg_y     (seg_y),
		.snake_len (snake_len),
		.apple_hit (apple_hit),
		.collision (collision),
		.scan_done (scan_done)
	);

	apple_placer u_apple (
		.clk     (clk),
		.rst     (rst),
		.state   (state),
		.apple_x (apple_x),
		.apple_y (apple_y)
	);

	frame_painter u_painter (
		.clk        (clk),
		.rst        (rst),
		.state      (state),
		.snake_len  (snake_len),
		.apple_x    (apple_x),
		.apple_y    (apple_y),
		.seg_x      (seg_x),
		.seg_y      (seg_y),
		.seg_index  (seg_index),
		.plot       (plot),
		.draw_x     (draw_x),
		.draw_y     (draw_y),
		.colour     (colour),
		.phase_done (phase_done)
	);

endmodule

// File: logic/snake_pkg.sv
`include "snake_settings.svh"

package snake_pkg;

	// screen coordinates, column and row
	typedef logic [7:0] coord_x_t;
	typedef logic [6:0] coord_y_t;
	// segment count, wide enough to hold MAX_LEN itself
	typedef logic [5:0] snake_len_t;
	// one bit per channel, {r, g, b}
	typedef logic [2:0] colour_t;
	// painter count, column in bits 14:7 and row in bits 6:0
	typedef logic [14:0] pix_count_t;

	typedef enum logic [1:0] {
		dir_left  = 2'b00,
		dir_right = 2'b01,
		dir_down  = 2'b10,
		dir_up    = 2'b11
	} dir_t;

	// menu and score menu share st_menu
	typedef enum logic [3:0] {
		st_menu, st_starting, st_start_wait,
		st_load, st_place_apple,
		st_clear, st_walls, st_apple, st_snake,
		st_delay, st_moving, st_check, st_eating, st_dead
	} game_state_t;

	localparam colour_t black = 3'd0;
	localparam colour_t blue  = 3'd1;
	localparam colour_t green = 3'd2;
	localparam colour_t red   = 3'd4;

	// high for any point on the wall band or outside the field
	function automatic logic in_wall(coord_x_t x, coord_y_t y);
		return (x < `WALL_LO) || (x > `WALL_X_HI) || (y < `WALL_LO) || (y > `WALL_Y_HI);
	endfunction

endpackage

// File: logic/snake_settings.svh
`ifndef SNAKE_SETTINGS_SVH
`define SNAKE_SETTINGS_SVH

// frame size in pixels
`define SCREEN_W 160
`define SCREEN_H 120

// wall band, a point below LO or above HI on either axis is wall
`define WALL_LO 2
`define WALL_X_HI 119
`define WALL_Y_HI 117

// head position after a (re)start, the body trails off to the right
`define START_X 30
`define START_Y 20
`define START_LEN 5

// segment storage depth
`define MAX_LEN 32

// idle clocks between two moves
`define DELAY_TICKS 64

// apples land in APPLE_OFFSET .. APPLE_OFFSET + APPLE_SPAN - 1
`define APPLE_SPAN 100
`define APPLE_OFFSET 2

`endif

// File: run_sim.sh
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal -f sim.f --top-module snake_game_tb \
	-Mdir obj_dir -o snake_sim > build.log 2>&1 || { cat build.log; exit 1; }
./obj_dir/snake_sim > sim.log 2>&1
cat sim.log
grep -q "ALL TESTS PASSED" sim.log && echo "simulation passed" || { echo "simulation failed"; exit 1; }

// File: sim.f
+incdir+logic
logic/snake_pkg.sv
logic/snake_control.sv
logic/snake_body.sv
logic/apple_placer.sv
logic/frame_painter.sv
logic/snake_game.sv
tb/snake_game_asserts.sv
tb/snake_game_tb.sv

// File: tb/snake_game_asserts.sv
`timescale 1ns/1ps
`include "snake_settings.svh"

module snake_game_asserts (
	input  logic clk,
	input  logic rst,
	input  logic plot,
	input  snake_pkg::coord_x_t draw_x,
	input  snake_pkg::coord_y_t draw_y,
	input  logic game_over,
	input  snake_pkg::snake_len_t snake_len
);
	import snake_pkg::*;

	// death is a single cycle strobe
	game_over_pulse: assert property (@(posedge clk) disable iff (rst)
		game_over |=> !game_over)
		else $error("game_over held high for more than one cycle");

	// every plotted pixel must land on the 160x120 frame
	pixel_on_screen: assert property (@(posedge clk) disable iff (rst)
		plot |-> (draw_x < `SCREEN_W) && (draw_y < `SCREEN_H))
		else $error("plotted pixel outside the screen");

	// segment count bounded by storage depth
	len_bounded: assert property (@(posedge clk) disable iff (rst)
		snake_len <= `MAX_LEN)
		else $error("snake_len above segment storage depth");

endmodule

bind snake_game snake_game_asserts u_asserts (.*);

// File: tb/snake_game_tb.sv
`timescale 1ns/1ps
`include "snake_settings.svh"

module snake_game_tb;
	import snake_pkg::*;

	localparam int FRAME_TIMEOUT = 60000;

	logic clk;
	logic rst;
	logic btn_left;
	logic btn_right;
	logic btn_down;
	logic btn_up;
	logic plot;
	coord_x_t draw_x;
	coord_y_t draw_y;
	colour_t colour;
	logic game_over;
	snake_len_t snake_len;

	int errors;
	int checks;
	integer seed;
	logic hung;
	logic died;
	// reference snake with the head in entry 0
	int mx [`MAX_LEN];
	int my [`MAX_LEN];
	int mlen;
	dir_t mdir;
	logic mcoll;
	int apx;
	int apy;
	// decoded frame
	int n_black;
	int n_blue;
	int n_red;
	int n_green;
	int rx;
	int ry;
	int gx [`MAX_LEN];
	int gy [`MAX_LEN];

	snake_game UUT (
		.clk       (clk),
		.rst       (rst),
		.btn_left  (btn_left),
		.btn_right (btn_right),
		.btn_down  (btn_down),
		.btn_up    (btn_up),
		.plot      (plot),
		.draw_x    (draw_x),
		.draw_y    (draw_y),
		.colour    (colour),
		.game_over (game_over),
		.snake_len (snake_len)
	);

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	// number of blue pixels in one wall scan
	function automatic int wall_pixels();
		int n;
		n = 0;
		for (int x = 0; x < `SCREEN_W; x++)
			for (int y = 0; y < `SCREEN_H; y++)
				if (x < `WALL_LO || x > `WALL_X_HI || y < `WALL_LO || y > `WALL_Y_HI)
					n++;
		return n;
	endfunction

	function automatic dir_t opposite(dir_t d);
		case (d)
			dir_left:  return dir_right;
			dir_right: return dir_left;
			dir_down:  return dir_up;
			default:   return dir_down;
		endcase
	endfunction

	// heading after a move from the held buttons in priority order without reversals
	function automatic dir_t ref_dir(dir_t cur, logic l, logic r, logic d, logic u);
		if (l && cur != dir_right)
			return dir_left;
		if (r && cur != dir_left)
			return dir_right;
		if (d && cur != dir_up)
			return dir_down;
		if (u && cur != dir_down)
			return dir_up;
		return cur;
	endfunction

	// head on a wall or on one of its own segments
	function automatic logic ref_collides();
		if (mx[0] < `WALL_LO || mx[0] > `WALL_X_HI || my[0] < `WALL_LO || my[0] > `WALL_Y_HI)
			return 1'b1;
		for (int i = 1; i < mlen; i++)
			if (mx[i] == mx[0] && my[i] == my[0])
				return 1'b1;
		return 1'b0;
	endfunction

	// greedy route to the apple that never asks for a reversal
	function automatic dir_t steer_dir();
		dir_t hx;
		dir_t vy;
		hx = (apx < mx[0]) ? dir_left : dir_right;
		vy = (apy < my[0]) ? dir_up : dir_down;
		if (apx != mx[0] && mdir != opposite(hx))
			return hx;
		if (apy != my[0] && mdir != opposite(vy))
			return vy;
		if (apx != mx[0])
			return (my[0] > 30) ? dir_up : dir_down;
		return (mx[0] > 30) ? dir_left : dir_right;
	endfunction

	task automatic check(input logic ok, input string msg);
		checks++;
		assert (ok) else begin
			errors++;
			$display("Fail %0t: %s", $time, msg);
		end
	endtask

	task automatic model_load();
		for (int i = 0; i < `MAX_LEN; i++) begin
			mx[i] = `START_X + i;
			my[i] = `START_Y;
		end
		mlen = `START_LEN;
		mdir = dir_left;
		mcoll = 1'b0;
	endtask

	// gathers pixels until the snake run is complete or game_over shows
	task automatic collect_frame();
		n_black = 0;
		n_blue = 0;
		n_red = 0;
		n_green = 0;
		died = 1'b0;
		if (hung)
			return;
		for (int t = 0; t < FRAME_TIMEOUT; t++) begin
			@(negedge clk);
			if (game_over) begin
				died = 1'b1;
				return;
			end
			if (plot) begin
				if (colour == black)
					n_black++;
				else if (colour == blue)
					n_blue++;
				else if (colour == red) begin
					n_red++;
					rx = draw_x;
					ry = draw_y;
				end else if (colour == green && n_red > 0) begin
					if (n_green < `MAX_LEN) begin
						gx[n_green] = draw_x;
						gy[n_green] = draw_y;
					end
					n_green++;
					if (n_green >= int'(snake_len))
						return;
				end else
					check(1'b0, $sformatf("unexpected colour %0d", colour));
			end
		end
		$display("timeout: no complete frame within %0d cycles", FRAME_TIMEOUT);
		errors++;
		hung = 1'b1;
	endtask

	task automatic check_frame();
		check(n_black == `SCREEN_W * `SCREEN_H, $sformatf("black count %0d", n_black));
		check(n_blue == wall_pixels(), $sformatf("blue count %0d", n_blue));
		check(n_red == 1, $sformatf("red count %0d", n_red));
		check(rx >= 2 && rx <= 101 && ry >= 2 && ry <= 101,
			$sformatf("apple at %0d,%0d out of range", rx, ry));
		check(int'(snake_len) == mlen, $sformatf("snake_len %0d, expected %0d", snake_len, mlen));
		check(n_green == mlen, $sformatf("green count %0d, expected %0d", n_green, mlen));
		for (int i = 0; i < mlen && i < n_green; i++)
			check(gx[i] == mx[i] && gy[i] == my[i],
				$sformatf("segment %0d at %0d,%0d, expected %0d,%0d",
				i, gx[i], gy[i], mx[i], my[i]));
		apx = rx;
		apy = ry;
	endtask

	// one move with the given buttons held and the frame that follows
	task automatic run_step(input logic l, input logic r, input logic d, input logic u);
		logic eat;
		logic expect_over;
		btn_left = l;
		btn_right = r;
		btn_down = d;
		btn_up = u;
		expect_over = mcoll;
		eat = 1'b0;
		if (!mcoll) begin
			eat = (mx[0] == apx) && (my[0] == apy);
			mdir = ref_dir(mdir, l, r, d, u);
			for (int i = `MAX_LEN - 1; i > 0; i--) begin
				mx[i] = mx[i-1];
				my[i] = my[i-1];
			end
			case (mdir)
				dir_left:  mx[0] = mx[0] - 1;
				dir_right: mx[0] = mx[0] + 1;
				dir_down:  my[0] = my[0] + 1;
				default:   my[0] = my[0] - 1;
			endcase
			// growth keeps the old tail and skips the scan on that step
			if (eat && mlen < `MAX_LEN)
				mlen++;
			if (!eat)
				mcoll = ref_collides();
		end
		collect_frame();
		if (hung)
			return;
		if (died) begin
			btn_left = 1'b0;
			btn_right = 1'b0;
			btn_down = 1'b0;
			btn_up = 1'b0;
		end
		check(died == expect_over, $sformatf("game_over %0b, expected %0b", died, expect_over));
		if (!died && !expect_over)
			check_frame();
	endtask

	task automatic press_dir(input dir_t d);
		run_step(d == dir_left, d == dir_right, d == dir_down, d == dir_up);
	endtask

	task automatic idle_step();
		run_step(1'b0, 1'b0, 1'b0, 1'b0);
	endtask

	// random length press and release before the first frame
	task automatic start_game();
		int hold;
		hold = 3 + ($unsigned($random(seed)) % 8);
		btn_down = 1'b1;
		repeat (hold) @(negedge clk);
		btn_down = 1'b0;
		model_load();
		collect_frame();
		if (hung)
			return;
		check(!died, "game_over during the first frame");
		check_frame();
		check(gx[0] == `START_X && gy[0] == `START_Y, "head not at start position");
	endtask

	initial begin
		int len0;
		int n;
		int col0;
		int row0;
		int last_x;
		dir_t hdir;
		dir_t vdir;
		seed = 32'hdc86_1f3f;
		errors = 0;
		checks = 0;
		hung = 1'b0;
		died = 1'b0;
		apx = -1;
		apy = -1;
		btn_left = 1'b0;
		btn_right = 1'b0;
		btn_down = 1'b0;
		btn_up = 1'b0;
		rst = 1'b1;
		repeat (8) @(negedge clk);
		rst = 1'b0;

		// quiet menu until a press
		repeat (100) begin
			@(negedge clk);
			check(!plot && !game_over, "plot or game_over active before start");
		end
		start_game();

		// straight run left
		repeat (3) idle_step();

		// holding right is refused while moving left
		col0 = gx[0];
		row0 = gy[0];
		press_dir(dir_right);
		check(gx[0] == col0 - 1 && gy[0] == row0,
			$sformatf("head at %0d,%0d after holding right", gx[0], gy[0]));
		// holding up turns the snake
		press_dir(dir_up);
		check(gy[0] == row0 - 1, $sformatf("head row %0d after turning up", gy[0]));
		idle_step();
		check(gy[0] == row0 - 2, $sformatf("head row %0d moving up", gy[0]));

		// chase the apple
		len0 = mlen;
		n = 0;
		while (!hung && !died && mlen == len0 && n < 400) begin
			press_dir(steer_dir());
			n++;
		end
		check(int'(snake_len) == len0 + 1,
			$sformatf("snake_len %0d after the apple, expected %0d", snake_len, len0 + 1));

		// straight horizontal run and then a tight loop into its own body
		hdir = (mx[0] > 40) ? dir_left : dir_right;
		vdir = (my[0] > 30) ? dir_up : dir_down;
		if (mdir == opposite(hdir))
			press_dir(vdir);
		press_dir(hdir);
		for (int i = 0; i < mlen && !died && !hung; i++)
			idle_step();
		press_dir(vdir);
		press_dir(opposite(hdir));
		press_dir(opposite(vdir));
		n = 0;
		while (!hung && !died && n < 4) begin
			idle_step();
			n++;
		end
		check(died, "no game_over after running into the body");

		// restart and run into the left wall
		start_game();
		last_x = -1;
		n = 0;
		died = 1'b0;
		while (!hung && !died && n < 40) begin
			idle_step();
			if (!died)
				last_x = gx[0];
			n++;
		end
		check(died, "no game_over at the wall");
		check(last_x == 1, $sformatf("last head column %0d before wall death", last_x));
		start_game();
		check(snake_len == `START_LEN, "snake_len not reset on restart");

		$display("checks: %0d errors: %0d", checks, errors);
		if (errors == 0 && !hung) begin
			$display("ALL TESTS PASSED");
		end else begin
			$display("SOME TESTS FAILED");
		end
		$finish;
	end

endmodule
